//--- src/mvm_defines.svh
`ifndef MVM_DEFINES_SVH
`define MVM_DEFINES_SVH

// ----------------------------------------------------------
// Stream widths
// ----------------------------------------------------------
// Full tdata word, four lanes or one result
`define MVM_DATAW      32
// Input precision of one lane
`define MVM_LANEW      8
`define MVM_LANES      4
`define MVM_DESTW      2
// Op code carried in tuser
`define MVM_USERW      2
// tid doubles as the weight address
`define MVM_IDW        2

// ----------------------------------------------------------
// Fabric size
// ----------------------------------------------------------
// Weight words per tile
`define MVM_RF_DEPTH   4
`define MVM_NUM_TILES  3

`endif

//--- src/mvm_pkg.sv
`default_nettype none

`include "mvm_defines.svh"

package mvm_pkg;

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------
    // Four packed lanes on the way in, one 32-bit sum on the way out
    typedef logic [`MVM_DATAW-1:0] data_t;

    // One signed input lane
    typedef logic signed [`MVM_LANEW-1:0] lane_t;

    // Tile index in tdest
    typedef logic [`MVM_DESTW-1:0] dest_t;

    // Weight register-file address in tid
    typedef logic [`MVM_IDW-1:0] rf_addr_t;

    // ----------------------------------------------------------
    // Operations in tuser
    // ----------------------------------------------------------
    // Code 3 is reserved and only travels down the chain
    typedef enum logic [`MVM_USERW-1:0] {
        OP_LOAD_WEIGHTS = 2'd0,
        OP_DOT          = 2'd1,
        OP_RESULT       = 2'd2
    } mvm_op_e;

endpackage

`default_nettype wire

//--- src/axis_if.sv
`default_nettype none

// One AXI-Stream link between two stages of the chain
interface axis_if
    import mvm_pkg::*;
();

    // Handshake
    logic     tvalid;
    logic     tready;

    // Payload, held with tvalid until the transfer
    data_t    tdata;
    mvm_op_e  tuser;
    rf_addr_t tid;
    dest_t    tdest;
    logic     tlast;

    // Upstream side of the link
    modport src (
        output tvalid,
        input  tready,
        output tdata,
        output tuser,
        output tid,
        output tdest,
        output tlast
    );

    // Downstream side, only ready flows back
    modport dst (
        input  tvalid,
        output tready,
        input  tdata,
        input  tuser,
        input  tid,
        input  tdest,
        input  tlast
    );

endinterface

`default_nettype wire

//--- src/axis_ingress.sv
`default_nettype none

`include "mvm_defines.svh"

module axis_ingress
    import mvm_pkg::*;
(
    input  wire           clk,
    input  wire           arst_n,

    // ----------------------------------------------------------
    // Stream in from the top level
    // ----------------------------------------------------------
    input  wire           s_tvalid,
    output logic          s_tready,
    input  wire data_t    s_tdata,
    input  wire mvm_op_e  s_tuser,
    input  wire rf_addr_t s_tid,
    input  wire dest_t    s_tdest,
    input  wire           s_tlast,

    // One-cycle pulse per dropped flit
    output logic          bad_dest,

    // Stream out to tile 0
    axis_if.src           m
);

    logic accept;
    logic dest_ok;

    // Register free, or emptied by downstream this cycle
    assign s_tready = !m.tvalid || m.tready;
    assign accept   = s_tvalid && s_tready;

    // Only tiles 0 .. N-1 exist
    assign dest_ok  = (s_tdest < `MVM_NUM_TILES);

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m.tvalid <= 1'b0;
            bad_dest <= 1'b0;
        end else begin
            // Bad flit is taken from the bus and dropped here
            bad_dest <= accept && !dest_ok;
            if (s_tready) begin
                m.tvalid <= s_tvalid && dest_ok;
            end
        end
    end

    // Payload only loads for flits that go on
    always_ff @(posedge clk) begin
        if (accept && dest_ok) begin
            m.tdata <= s_tdata;
            m.tuser <= s_tuser;
            m.tid   <= s_tid;
            m.tdest <= s_tdest;
            m.tlast <= s_tlast;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    // Stalled flit keeps its valid and payload until tile 0 takes it
    a_hold_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        m.tvalid && !m.tready |=> m.tvalid && $stable(m.tdata) && $stable(m.tuser)
            && $stable(m.tid) && $stable(m.tdest) && $stable(m.tlast)
    );

endmodule

`default_nettype wire

//--- src/mvm_tile.sv
`default_nettype none

`include "mvm_defines.svh"

module mvm_tile
    import mvm_pkg::*;
#(
    // Index this tile answers to in tdest
    parameter int TILE_ID = 0
) (
    input  wire clk,
    input  wire arst_n,

    // Flits from the previous stage
    axis_if.dst s,

    // Flits to the next stage
    axis_if.src m
);

    // ----------------------------------------------------------
    // Declarations
    // ----------------------------------------------------------
    // Weight register file, one packed four-lane word per entry
    data_t weights [`MVM_RF_DEPTH];

    // Entry addressed by the incoming tid
    data_t rd_weights;

    logic  accept;
    logic  match;
    logic  load_en;
    logic  dot_en;
    logic  fwd_en;

    logic signed [`MVM_DATAW-1:0] dot_sum;

    // ----------------------------------------------------------
    // Flit decode
    // ----------------------------------------------------------
    // Same rule at every stage, so a chain of N holds N flits
    assign s.tready = !m.tvalid || m.tready;
    assign accept   = s.tvalid && s.tready;

    assign match    = (s.tdest == dest_t'(TILE_ID));
    assign load_en  = accept && match && (s.tuser == OP_LOAD_WEIGHTS);
    assign dot_en   = accept && match && (s.tuser == OP_DOT);

    // Everything except a local load goes to the output register
    assign fwd_en   = accept && !(match && (s.tuser == OP_LOAD_WEIGHTS));

    // ----------------------------------------------------------
    // Weight register file
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Unloaded entries read as zero weights
            for (int i = 0; i < `MVM_RF_DEPTH; i++) begin
                weights[i] <= '0;
            end
        end else if (load_en) begin
            weights[s.tid] <= s.tdata;
        end
    end

    assign rd_weights = weights[s.tid];

    // ----------------------------------------------------------
    // Dot-product unit
    // ----------------------------------------------------------
    always_comb begin : dot_unit
        lane_t a;
        lane_t b;
        dot_sum = '0;
        for (int i = 0; i < `MVM_LANES; i++) begin
            a = lane_t'(s.tdata[i*`MVM_LANEW +: `MVM_LANEW]);
            b = lane_t'(rd_weights[i*`MVM_LANEW +: `MVM_LANEW]);
            // Both signed, so products sign-extend into the sum
            dot_sum = dot_sum + a * b;
        end
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m.tvalid <= 1'b0;
        end else if (s.tready) begin
            // Either refilled or drained this cycle
            m.tvalid <= fwd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_en) begin
            if (dot_en) begin
                // Dot flit turns into a result stamped with this tile
                m.tdata <= data_t'(dot_sum);
                m.tuser <= OP_RESULT;
                m.tdest <= dest_t'(TILE_ID);
            end else begin
                m.tdata <= s.tdata;
                m.tuser <= s.tuser;
                m.tdest <= s.tdest;
            end
            // tid and tlast ride along either way
            m.tid   <= s.tid;
            m.tlast <= s.tlast;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    // Results only come from upstream tiles with other indices
    a_no_local_result : assert property (
        @(posedge clk) disable iff (!arst_n)
        s.tvalid && match |-> s.tuser != OP_RESULT
    );

    // No flit leaves while the chain is held in reset
    a_idle_in_reset : assert property (
        @(posedge clk)
        !arst_n |-> !m.tvalid
    );

endmodule

`default_nettype wire

//--- src/axis_egress.sv
`default_nettype none

module axis_egress
    import mvm_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n,

    // Last link of the chain
    axis_if.dst       s,

    // ----------------------------------------------------------
    // Result stream to the top level
    // ----------------------------------------------------------
    output logic      m_tvalid,
    input  wire       m_tready,
    output data_t     m_tdata,
    output mvm_op_e   m_tuser,
    output rf_addr_t  m_tid,
    output dest_t     m_tdest,
    output logic      m_tlast
);

    // Skid entry, filled only while the output is stalled
    logic     skid_valid;
    data_t    skid_tdata;
    rf_addr_t skid_tid;
    dest_t    skid_tdest;
    logic     skid_tlast;

    logic     keep;
    logic     out_free;

    // Ready straight from a flop, cuts the combinational ready chain
    assign s.tready = !skid_valid;

    // Pass-through and reserved flits are accepted and dropped
    assign keep     = s.tvalid && s.tready && (s.tuser == OP_RESULT);
    assign out_free = !m_tvalid || m_tready;

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid   <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // Skid drains first, keeps order
            m_tvalid   <= skid_valid || keep;
            skid_valid <= 1'b0;
        end else if (keep) begin
            skid_valid <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Payload
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (out_free && skid_valid) begin
            m_tdata <= skid_tdata;
            m_tid   <= skid_tid;
            m_tdest <= skid_tdest;
            m_tlast <= skid_tlast;
        end else if (out_free && keep) begin
            m_tdata <= s.tdata;
            m_tid   <= s.tid;
            m_tdest <= s.tdest;
            m_tlast <= s.tlast;
        end
        if (!out_free && keep) begin
            skid_tdata <= s.tdata;
            skid_tid   <= s.tid;
            skid_tdest <= s.tdest;
            skid_tlast <= s.tlast;
        end
    end

    // Everything kept here is a result
    assign m_tuser = OP_RESULT;

    // Output held steady while the consumer stalls
    a_out_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tid)
            && $stable(m_tdest) && $stable(m_tlast)
    );

endmodule

`default_nettype wire

//--- src/mvm_chain_top.sv
`default_nettype none

`include "mvm_defines.svh"

module mvm_chain_top
    import mvm_pkg::*;
(
    input  wire           clk,
    input  wire           arst_n,

    // ----------------------------------------------------------
    // Stream in
    // ----------------------------------------------------------
    input  wire           s_tvalid,
    output logic          s_tready,
    input  wire data_t    s_tdata,
    input  wire mvm_op_e  s_tuser,
    input  wire rf_addr_t s_tid,
    input  wire dest_t    s_tdest,
    input  wire           s_tlast,

    // ----------------------------------------------------------
    // Result stream out
    // ----------------------------------------------------------
    output logic          m_tvalid,
    input  wire           m_tready,
    output data_t         m_tdata,
    output mvm_op_e       m_tuser,
    output rf_addr_t      m_tid,
    output dest_t         m_tdest,
    output logic          m_tlast,

    // Pulses once per flit aimed at a missing tile
    output logic          bad_dest
);

    // Link 0 feeds tile 0, link k+1 leaves tile k, last one feeds egress
    axis_if link [`MVM_NUM_TILES+1] ();

    // ----------------------------------------------------------
    // Ingress
    // ----------------------------------------------------------
    axis_ingress ingress_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tuser  (s_tuser),
        .s_tid    (s_tid),
        .s_tdest  (s_tdest),
        .s_tlast  (s_tlast),
        .bad_dest (bad_dest),
        .m        (link[0])
    );

    // ----------------------------------------------------------
    // Tile chain
    // ----------------------------------------------------------
    genvar k;
    generate
        for (k = 0; k < `MVM_NUM_TILES; k = k + 1) begin : tile_loop
            mvm_tile #(
                .TILE_ID (k)
            ) tile_inst (
                .clk    (clk),
                .arst_n (arst_n),
                .s      (link[k]),
                .m      (link[k+1])
            );
        end
    endgenerate

    // Egress, only results reach the output ports
    axis_egress egress_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .s        (link[`MVM_NUM_TILES]),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tuser  (m_tuser),
        .m_tid    (m_tid),
        .m_tdest  (m_tdest),
        .m_tlast  (m_tlast)
    );

endmodule

`default_nettype wire

//--- sim/tb_mvm_chain.sv
`default_nettype none

`include "mvm_defines.svh"

module tb_mvm_chain
    import mvm_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int WAIT_LIMIT     = 200;
    // Ingress, one cycle per tile, egress
    localparam int LATENCY        = `MVM_NUM_TILES + 2;

    logic     clk;
    logic     arst_n;
    logic     s_tvalid;
    logic     s_tready;
    data_t    s_tdata;
    mvm_op_e  s_tuser;
    rf_addr_t s_tid;
    dest_t    s_tdest;
    logic     s_tlast;
    logic     m_tvalid;
    logic     m_tready;
    data_t    m_tdata;
    mvm_op_e  m_tuser;
    rf_addr_t m_tid;
    dest_t    m_tdest;
    logic     m_tlast;
    logic     bad_dest;

    integer seed            = 66248;
    integer errors          = 0;
    integer checks          = 0;
    integer cyc             = 0;
    integer bad_count       = 0;
    integer out_count       = 0;
    integer last_accept_cyc = 0;
    integer last_result_cyc = 0;
    logic   stream_done     = 1'b0;

    // Weights as the testbench has loaded them
    data_t w_model [`MVM_NUM_TILES][`MVM_RF_DEPTH];

    // Dot flits waiting to be streamed
    dest_t    dot_dest_q [$];
    rf_addr_t dot_id_q [$];
    data_t    dot_data_q [$];
    logic     dot_last_q [$];

    mvm_chain_top uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tuser  (s_tuser),
        .s_tid    (s_tid),
        .s_tdest  (s_tdest),
        .s_tlast  (s_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tuser  (m_tuser),
        .m_tid    (m_tid),
        .m_tdest  (m_tdest),
        .m_tlast  (m_tlast),
        .bad_dest (bad_dest)
    );

    // ----------------------------------------------------------
    // Clock, cycle count and watchdog
    // ----------------------------------------------------------
    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // Outputs sampled mid-cycle, away from the active edge
    always @(negedge clk) begin
        if (bad_dest)
            bad_count = bad_count + 1;
        if (m_tvalid && m_tready)
            out_count = out_count + 1;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name,
                     expected, actual);
            errors = errors + 1;
        end
    endtask

    // Signed sum of four lane products, widened to 32 bits
    function automatic logic [31:0] ref_dot(input data_t lanes, input data_t wts);
        integer acc;
        integer a;
        integer b;
        acc = 0;
        for (int i = 0; i < `MVM_LANES; i++) begin
            a   = $signed(lanes[i*`MVM_LANEW +: `MVM_LANEW]);
            b   = $signed(wts[i*`MVM_LANEW +: `MVM_LANEW]);
            acc = acc + a * b;
        end
        return acc;
    endfunction

    task automatic reset_dut();
        arst_n = 1'b0;
        for (int t = 0; t < `MVM_NUM_TILES; t++)
            for (int r = 0; r < `MVM_RF_DEPTH; r++)
                w_model[t][r] = '0;
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
    endtask

    // Entered and left one unit after a rising edge
    task automatic send_flit(input mvm_op_e op, input dest_t dest, input rf_addr_t id,
                             input data_t data, input logic last);
        integer waited;
        waited   = 0;
        s_tvalid = 1'b1;
        s_tuser  = op;
        s_tdest  = dest;
        s_tid    = id;
        s_tdata  = data;
        s_tlast  = last;
        @(negedge clk);
        while (!s_tready && waited < WAIT_LIMIT) begin
            waited = waited + 1;
            @(negedge clk);
        end
        if (!s_tready) begin
            $display("Input never became ready at time %0t", $time);
            errors = errors + 1;
        end
        @(posedge clk);
        #1 s_tvalid = 1'b0;
        last_accept_cyc = cyc;
    endtask

    task automatic send_load(input dest_t tile, input rf_addr_t addr, input data_t wts);
        w_model[tile][addr] = wts;
        send_flit(OP_LOAD_WEIGHTS, tile, addr, wts, 1'b0);
    endtask

    task automatic expect_result(input data_t exp_data, input dest_t exp_dest,
                                 input rf_addr_t exp_id, input logic exp_last);
        integer waited;
        waited = 0;
        @(negedge clk);
        while (!(m_tvalid && m_tready) && waited < WAIT_LIMIT) begin
            waited = waited + 1;
            @(negedge clk);
        end
        if (!(m_tvalid && m_tready)) begin
            $display("No result arrived within %0d cycles at time %0t", WAIT_LIMIT, $time);
            errors = errors + 1;
        end else begin
            check_value("m_tdata", exp_data, m_tdata);
            check_value("m_tuser", OP_RESULT, m_tuser);
            check_value("m_tdest", exp_dest, m_tdest);
            check_value("m_tid", exp_id, m_tid);
            check_value("m_tlast", exp_last, m_tlast);
        end
        @(posedge clk);
        #1 last_result_cyc = cyc;
    endtask

    task automatic queue_dot(input dest_t tile, input rf_addr_t addr, input data_t lanes,
                             input logic last);
        dot_dest_q.push_back(tile);
        dot_id_q.push_back(addr);
        dot_data_q.push_back(lanes);
        dot_last_q.push_back(last);
    endtask

    // Sender, receiver and optional output throttle run side by side
    task automatic stream_dots(input logic throttle);
        integer n;
        n           = dot_data_q.size();
        stream_done = 1'b0;
        fork
            begin
                for (int i = 0; i < n; i++)
                    send_flit(OP_DOT, dot_dest_q[i], dot_id_q[i], dot_data_q[i], dot_last_q[i]);
            end
            begin
                for (int j = 0; j < n; j++)
                    expect_result(ref_dot(dot_data_q[j], w_model[dot_dest_q[j]][dot_id_q[j]]),
                                  dot_dest_q[j], dot_id_q[j], dot_last_q[j]);
                stream_done = 1'b1;
            end
            begin
                while (throttle && !stream_done) begin
                    @(posedge clk);
                    #1 m_tready = (($random(seed) & 3) == 0);
                end
                m_tready = 1'b1;
            end
        join
        dot_dest_q.delete();
        dot_id_q.delete();
        dot_data_q.delete();
        dot_last_q.delete();
    endtask

    task automatic report_test(input string name);
        $display("%s finished, %0d errors so far", name, errors);
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    task automatic test_single_dot();
        data_t wts;
        data_t lanes;
        wts   = {8'sd4, -8'sd3, 8'sd2, 8'sd1};
        lanes = {8'sd5, 8'sd6, -8'sd7, 8'sd8};
        send_load(0, 1, wts);
        send_flit(OP_DOT, 0, 1, lanes, 1'b1);
        expect_result(ref_dot(lanes, wts), 0, 1, 1'b1);
        check_value("latency", LATENCY, last_result_cyc - last_accept_cyc);
        report_test("test 1 single dot product");
    endtask

    task automatic test_all_tiles();
        for (int t = 0; t < `MVM_NUM_TILES; t++)
            for (int r = 0; r < `MVM_RF_DEPTH; r++)
                send_load(t, r, $random(seed));
        for (int t = 0; t < `MVM_NUM_TILES; t++)
            for (int r = 0; r < `MVM_RF_DEPTH; r++)
                queue_dot(t, r, $random(seed), r[0]);
        stream_dots(1'b0);
        report_test("test 2 every tile and address");
    endtask

    task automatic test_signed_extremes();
        send_load(1, 2, {4{8'h80}});
        send_load(2, 0, {4{8'h80}});
        // 4 * (-128 * -128) and 4 * (127 * -128)
        queue_dot(1, 2, {4{8'h80}}, 1'b0);
        queue_dot(2, 0, {4{8'h7f}}, 1'b1);
        stream_dots(1'b0);
        report_test("test 3 signed extremes");
    endtask

    task automatic test_bad_dest();
        integer bad_before;
        integer out_before;
        bad_before = bad_count;
        out_before = out_count;
        // Result op, so a flit let through would survive the egress filter
        send_flit(OP_RESULT, 3, 0, $random(seed), 1'b1);
        // Long enough for a stray flit to reach the output
        repeat (LATENCY + 2) @(posedge clk);
        #1;
        check_value("bad_dest pulses", 1, bad_count - bad_before);
        check_value("outputs after bad flit", 0, out_count - out_before);
        queue_dot(0, 1, $random(seed), 1'b1);
        stream_dots(1'b0);
        report_test("test 4 bad destination");
    endtask

    task automatic test_backpressure();
        integer out_before;
        out_before = out_count;
        for (int i = 0; i < 10; i++)
            queue_dot($unsigned($random(seed)) % `MVM_NUM_TILES, $random(seed),
                      $random(seed), (i == 9));
        stream_dots(1'b1);
        repeat (LATENCY + 2) @(posedge clk);
        #1;
        check_value("result count", 10, out_count - out_before);
        report_test("test 5 back-pressure");
    endtask

    task automatic test_unloaded();
        reset_dut();
        check_value("s_tready", 1'b1, s_tready);
        check_value("m_tvalid", 1'b0, m_tvalid);
        check_value("bad_dest", 1'b0, bad_dest);
        send_flit(OP_DOT, 2, 3, $random(seed), 1'b0);
        expect_result(32'd0, 2, 3, 1'b0);
        report_test("test 6 unloaded weights after reset");
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        arst_n   = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tuser  = OP_LOAD_WEIGHTS;
        s_tid    = '0;
        s_tdest  = '0;
        s_tlast  = 1'b0;
        m_tready = 1'b1;
        reset_dut();
        test_single_dot();
        test_all_tiles();
        test_signed_extremes();
        test_bad_dest();
        test_backpressure();
        test_unloaded();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/mvm_pkg.sv
src/axis_if.sv
src/axis_ingress.sv
src/mvm_tile.sv
src/axis_egress.sv
src/mvm_chain_top.sv
sim/tb_mvm_chain.sv
